// ==== common/flight_pkg.sv ====
package flight_pkg;

	// Value types shared across the control chain
	typedef logic [9:0] rc_val_t;           // Stick value 0..1000
	typedef logic signed [15:0] imu_val_t;  // Euler angle or gyro rate, stick-scaled
	typedef logic signed [15:0] rate_t;     // Target rate or axis command
	typedef logic [9:0] motor_level_t;      // Motor level 0..1000

	// Receiver pulse decoder states
	typedef enum logic {
		wait_rise,
		measure
	} rc_state_t;

	// ESC frame states
	typedef enum logic {
		pulse_high,
		pulse_low
	} pwm_state_t;

	// Time base
	localparam int US_DIV = 4;              // sys_clk cycles per microsecond

	// Receiver scaling
	localparam int PULSE_MIN_US = 1000;     // Pulse width at stick zero
	localparam int RC_MAX = 1000;
	localparam int RC_CENTER = 500;

	// Loop tuning
	localparam int ANGLE_SHIFT = 1;
	localparam int KP_SHIFT = 1;
	localparam int KI_SHIFT = 3;
	localparam int INT_LIMIT = 2000;        // Integrator clamp, +/-
	localparam int CMD_LIMIT = 250;         // Axis command clamp, +/-

	// Motor output
	localparam int ARM_THRESHOLD = 50;      // Throttle below this keeps motors off
	localparam int PWM_PERIOD_US = 2500;    // ESC frame length

	// Axis indexing
	localparam int AXIS_COUNT = 3;
	localparam int AXIS_ROLL = 0;
	localparam int AXIS_PITCH = 1;
	localparam int AXIS_YAW = 2;

endpackage

// ==== verilog/us_tick.sv ====
module us_tick (
	input  logic sys_clk,
	input  logic resetn,
	output logic us_en
);
	import flight_pkg::*;

	logic [$clog2(US_DIV)-1:0] div_cnt;  // Cycle position inside the current microsecond
	logic div_wrap;

	assign div_wrap = (div_cnt == ($clog2(US_DIV))'(US_DIV - 1));

	// Registered enable, one cycle wide, once per US_DIV cycles
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			div_cnt <= '0;
			us_en <= 1'b0;
		end else begin
			us_en <= div_wrap;
			if (div_wrap) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== receiver/rc_pulse_decoder.sv ====
module rc_pulse_decoder (
	input  logic sys_clk,
	input  logic resetn,
	input  logic us_en,
	input  logic pwm_in,
	output flight_pkg::rc_val_t rc_val
);
	import flight_pkg::*;

	logic pwm_s1, pwm_s2, pwm_s3;  // Two sync stages plus one for edge detect
	logic rise, fall;
	rc_state_t state;
	logic [$clog2(PWM_PERIOD_US)-1:0] width_cnt;  // Ticks seen while high
	logic [$clog2(PWM_PERIOD_US)-1:0] width_q;    // Width captured at the falling edge
	logic [$clog2(PWM_PERIOD_US)-1:0] excess;
	logic conv_pend;                              // Width waiting for the next tick
	rc_val_t conv_val;

	assign rise = pwm_s2 & ~pwm_s3;
	assign fall = ~pwm_s2 & pwm_s3;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			{pwm_s1, pwm_s2, pwm_s3} <= 3'b000;
		end else begin
			{pwm_s1, pwm_s2, pwm_s3} <= {pwm_in, pwm_s1, pwm_s2};
		end
	end

	// Pulse width counter, saturates instead of wrapping on a stuck-high input
	always_ff @(posedge sys_clk) begin
		if (state == wait_rise && rise) begin
			width_cnt <= {{($bits(width_cnt) - 1){1'b0}}, us_en};  // Tick on the rising cycle counts
		end else if (state == measure && pwm_s2 && us_en && width_cnt != '1) begin
			width_cnt <= width_cnt + 1'b1;
		end
		if (state == measure && fall) width_q <= width_cnt;
	end

	// Subtract the zero offset, floor at 0 and cap at full stick
	assign excess = width_q - ($bits(width_q))'(PULSE_MIN_US);
	always_comb begin
		if (width_q < ($bits(width_q))'(PULSE_MIN_US)) begin
			conv_val = '0;
		end else if (excess > ($bits(excess))'(RC_MAX)) begin
			conv_val = rc_val_t'(RC_MAX);
		end else begin
			conv_val = rc_val_t'(excess);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			state <= wait_rise;
			conv_pend <= 1'b0;
			rc_val <= '0;
		end else begin
			if (conv_pend && us_en) begin
				rc_val <= conv_val;  // Held until the next pulse completes
				conv_pend <= 1'b0;
			end
			case (state)
				wait_rise: if (rise) state <= measure;
				measure: begin
					if (fall) begin
						state <= wait_rise;
						conv_pend <= 1'b1;
					end
				end
				default: state <= wait_rise;
			endcase
		end
	end

endmodule

// ==== control/angle_controller.sv ====
module angle_controller (
	input  logic sys_clk,
	input  logic resetn,
	input  logic imu_valid,
	input  flight_pkg::rc_val_t roll_stick,
	input  flight_pkg::rc_val_t pitch_stick,
	input  flight_pkg::rc_val_t yaw_stick,
	input  flight_pkg::imu_val_t euler_roll,
	input  flight_pkg::imu_val_t euler_pitch,
	output flight_pkg::rate_t roll_target,
	output flight_pkg::rate_t pitch_target,
	output flight_pkg::rate_t yaw_target,
	output logic rate_valid
);
	import flight_pkg::*;

	// One extra bit so stick offset minus a full-scale angle cannot wrap
	logic signed [16:0] roll_center, pitch_center;
	logic signed [16:0] roll_diff, pitch_diff;
	rate_t yaw_center;

	// Stick position relative to center
	assign roll_center = 17'($signed({7'd0, roll_stick})) - 17'(RC_CENTER);
	assign pitch_center = 17'($signed({7'd0, pitch_stick})) - 17'(RC_CENTER);
	assign yaw_center = rate_t'($signed({6'd0, yaw_stick})) - rate_t'(RC_CENTER);

	// Angle error, stick is the commanded attitude
	assign roll_diff = roll_center - 17'(euler_roll);
	assign pitch_diff = pitch_center - 17'(euler_pitch);

	always_ff @(posedge sys_clk) begin
		if (imu_valid) begin
			roll_target <= rate_t'(roll_diff >>> ANGLE_SHIFT);
			pitch_target <= rate_t'(pitch_diff >>> ANGLE_SHIFT);
			yaw_target <= yaw_center;  // Yaw stick drives rate directly, no heading hold
		end
	end

	// Strobe follows the sample by exactly one cycle
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			rate_valid <= 1'b0;
		end else begin
			rate_valid <= imu_valid;
		end
	end

endmodule

// ==== control/axis_rate_controller.sv ====
module axis_rate_controller (
	input  logic sys_clk,
	input  logic resetn,
	input  logic rate_valid,
	input  flight_pkg::rate_t target_rate,
	input  flight_pkg::imu_val_t gyro_rate,
	output flight_pkg::rate_t axis_cmd,
	output logic cmd_valid
);
	import flight_pkg::*;

	logic signed [16:0] rate_err;   // Target minus measured, full range
	logic signed [16:0] err_q;      // Stage one error register
	rate_t integ;                   // Clamped to +/-INT_LIMIT so 16 bits suffice
	logic signed [17:0] integ_sum;
	rate_t integ_next;
	logic signed [17:0] cmd_sum;
	rate_t cmd_next;
	logic err_valid;                // Stage one strobe

	assign rate_err = 17'(target_rate) - 17'(gyro_rate);

	// Stage one, accumulate and clamp
	assign integ_sum = 18'(integ) + 18'(rate_err);
	always_comb begin
		if (integ_sum > 18'(INT_LIMIT)) begin
			integ_next = rate_t'(INT_LIMIT);
		end else if (integ_sum < -18'(INT_LIMIT)) begin
			integ_next = -rate_t'(INT_LIMIT);
		end else begin
			integ_next = rate_t'(integ_sum);
		end
	end

	// Stage two, P plus I from the same sample's registers
	assign cmd_sum = 18'(err_q >>> KP_SHIFT) + 18'(integ >>> KI_SHIFT);
	always_comb begin
		if (cmd_sum > 18'(CMD_LIMIT)) begin
			cmd_next = rate_t'(CMD_LIMIT);
		end else if (cmd_sum < -18'(CMD_LIMIT)) begin
			cmd_next = -rate_t'(CMD_LIMIT);
		end else begin
			cmd_next = rate_t'(cmd_sum);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rate_valid) err_q <= rate_err;
		if (err_valid) axis_cmd <= cmd_next;
	end

	// Integrator and strobes, back-to-back samples each advance one stage
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			integ <= '0;
			err_valid <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			if (rate_valid) integ <= integ_next;
			err_valid <= rate_valid;
			cmd_valid <= err_valid;
		end
	end

endmodule

// ==== control/motor_mixer.sv ====
module motor_mixer (
	input  logic sys_clk,
	input  logic resetn,
	input  logic [flight_pkg::AXIS_COUNT-1:0] cmd_valid,
	input  flight_pkg::rate_t roll_cmd,
	input  flight_pkg::rate_t pitch_cmd,
	input  flight_pkg::rate_t yaw_cmd,
	input  flight_pkg::rc_val_t throttle,
	output flight_pkg::motor_level_t motor_1_level,
	output flight_pkg::motor_level_t motor_2_level,
	output flight_pkg::motor_level_t motor_3_level,
	output flight_pkg::motor_level_t motor_4_level,
	output logic mix_valid
);
	import flight_pkg::*;

	// Throttle plus three clamped commands stays well inside 18 bits
	logic signed [17:0] thr_s, roll_s, pitch_s, yaw_s;
	logic signed [17:0] sum_1, sum_2, sum_3, sum_4;
	logic all_valid;
	logic armed;

	// Saturate a raw mix to the legal motor range
	function automatic motor_level_t clamp_level(input logic signed [17:0] sum);
		if (sum < 18'sd0) begin
			return '0;
		end else if (sum > 18'(RC_MAX)) begin
			return motor_level_t'(RC_MAX);
		end else begin
			return motor_level_t'(sum);
		end
	endfunction

	assign thr_s = 18'($signed({8'd0, throttle}));
	assign roll_s = 18'(roll_cmd);
	assign pitch_s = 18'(pitch_cmd);
	assign yaw_s = 18'(yaw_cmd);

	// X frame, props alternate spin direction
	assign sum_1 = thr_s + pitch_s + roll_s - yaw_s;  // Front right
	assign sum_2 = thr_s + pitch_s - roll_s + yaw_s;  // Front left
	assign sum_3 = thr_s - pitch_s - roll_s - yaw_s;  // Rear left
	assign sum_4 = thr_s - pitch_s + roll_s + yaw_s;  // Rear right

	assign all_valid = &cmd_valid;  // Axes share one pipeline, strobes always coincide
	assign armed = (throttle >= rc_val_t'(ARM_THRESHOLD));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motor_1_level <= '0;
			motor_2_level <= '0;
			motor_3_level <= '0;
			motor_4_level <= '0;
			mix_valid <= 1'b0;
		end else begin
			mix_valid <= all_valid;
			if (all_valid) begin
				motor_1_level <= armed ? clamp_level(sum_1) : '0;  // Low stick means disarmed
				motor_2_level <= armed ? clamp_level(sum_2) : '0;
				motor_3_level <= armed ? clamp_level(sum_3) : '0;
				motor_4_level <= armed ? clamp_level(sum_4) : '0;
			end
		end
	end

endmodule

// ==== verilog/esc_pwm_generator.sv ====
module esc_pwm_generator (
	input  logic sys_clk,
	input  logic resetn,
	input  logic us_en,
	input  flight_pkg::motor_level_t motor_level,
	output logic pwm_out
);
	import flight_pkg::*;

	pwm_state_t state;
	logic [$clog2(PWM_PERIOD_US)-1:0] frame_cnt;   // Microseconds into the frame
	logic [$clog2(PWM_PERIOD_US)-1:0] frame_next;
	logic [$clog2(PWM_PERIOD_US)-1:0] high_len;    // 1000 us idle pulse plus level
	motor_level_t level_q;                          // Frozen for the whole frame
	logic frame_end;

	assign frame_next = frame_cnt + 1'b1;
	assign frame_end = (frame_cnt == ($bits(frame_cnt))'(PWM_PERIOD_US - 1));
	assign high_len = ($bits(high_len))'(PULSE_MIN_US) + ($bits(high_len))'(level_q);

	always_ff @(posedge sys_clk) begin
		if (us_en && frame_end) level_q <= motor_level;  // Latch only at frame start
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			state <= pulse_low;  // First frame starts after one full period
			frame_cnt <= '0;
		end else if (us_en) begin
			if (frame_end) begin
				frame_cnt <= '0;
				state <= pulse_high;
			end else begin
				frame_cnt <= frame_next;
				if (state == pulse_high && frame_next == high_len) state <= pulse_low;
			end
		end
	end

	assign pwm_out = (state == pulse_high);

endmodule

// ==== verilog/flight_ctrl_top.sv ====
module flight_ctrl_top (
	input  logic sys_clk,
	input  logic resetn,
	input  logic throttle_pwm,
	input  logic roll_pwm,
	input  logic pitch_pwm,
	input  logic yaw_pwm,
	input  logic imu_valid,
	input  flight_pkg::imu_val_t euler_roll,
	input  flight_pkg::imu_val_t euler_pitch,
	input  flight_pkg::imu_val_t gyro_roll,
	input  flight_pkg::imu_val_t gyro_pitch,
	input  flight_pkg::imu_val_t gyro_yaw,
	output logic motor_1_pwm,
	output logic motor_2_pwm,
	output logic motor_3_pwm,
	output logic motor_4_pwm,
	output flight_pkg::motor_level_t motor_1_level,
	output flight_pkg::motor_level_t motor_2_level,
	output flight_pkg::motor_level_t motor_3_level,
	output flight_pkg::motor_level_t motor_4_level,
	output logic mix_valid
);
	import flight_pkg::*;

	logic us_en;                                     // Microsecond tick for receiver and ESC
	rc_val_t throttle_val, roll_val, pitch_val, yaw_val;
	rate_t target_rate [AXIS_COUNT];                 // Angle loop to rate loops
	imu_val_t gyro [AXIS_COUNT];
	rate_t axis_cmd [AXIS_COUNT];                    // Rate loops to mixer
	logic rate_valid;
	logic [AXIS_COUNT-1:0] cmd_valid;

	assign gyro[AXIS_ROLL] = gyro_roll;
	assign gyro[AXIS_PITCH] = gyro_pitch;
	assign gyro[AXIS_YAW] = gyro_yaw;

	us_tick u_tick (.sys_clk, .resetn, .us_en);

	rc_pulse_decoder u_rc_throttle (.sys_clk, .resetn, .us_en,
		.pwm_in(throttle_pwm), .rc_val(throttle_val));
	rc_pulse_decoder u_rc_roll (.sys_clk, .resetn, .us_en, .pwm_in(roll_pwm), .rc_val(roll_val));
	rc_pulse_decoder u_rc_pitch (.sys_clk, .resetn, .us_en, .pwm_in(pitch_pwm), .rc_val(pitch_val));
	rc_pulse_decoder u_rc_yaw (.sys_clk, .resetn, .us_en, .pwm_in(yaw_pwm), .rc_val(yaw_val));

	// Started directly by the IMU data strobe
	angle_controller u_angle (
		.sys_clk, .resetn, .imu_valid,
		.roll_stick(roll_val), .pitch_stick(pitch_val), .yaw_stick(yaw_val),
		.euler_roll, .euler_pitch,
		.roll_target(target_rate[AXIS_ROLL]),
		.pitch_target(target_rate[AXIS_PITCH]),
		.yaw_target(target_rate[AXIS_YAW]),
		.rate_valid);

	// One PI loop per body axis
	for (genvar k = 0; k < AXIS_COUNT; k++) begin : g_axis
		axis_rate_controller u_rate (
			.sys_clk, .resetn, .rate_valid,
			.target_rate(target_rate[k]), .gyro_rate(gyro[k]),
			.axis_cmd(axis_cmd[k]), .cmd_valid(cmd_valid[k]));
	end

	motor_mixer u_mixer (
		.sys_clk, .resetn, .cmd_valid,
		.roll_cmd(axis_cmd[AXIS_ROLL]), .pitch_cmd(axis_cmd[AXIS_PITCH]),
		.yaw_cmd(axis_cmd[AXIS_YAW]), .throttle(throttle_val),
		.motor_1_level, .motor_2_level, .motor_3_level, .motor_4_level,
		.mix_valid);

	esc_pwm_generator u_esc_1 (.sys_clk, .resetn, .us_en,
		.motor_level(motor_1_level), .pwm_out(motor_1_pwm));
	esc_pwm_generator u_esc_2 (.sys_clk, .resetn, .us_en,
		.motor_level(motor_2_level), .pwm_out(motor_2_pwm));
	esc_pwm_generator u_esc_3 (.sys_clk, .resetn, .us_en,
		.motor_level(motor_3_level), .pwm_out(motor_3_pwm));
	esc_pwm_generator u_esc_4 (.sys_clk, .resetn, .us_en,
		.motor_level(motor_4_level), .pwm_out(motor_4_pwm));

endmodule

// ==== verif/flight_ctrl_chk.sv ====
module flight_ctrl_chk (
	input  logic sys_clk,
	input  logic resetn,
	input  logic imu_valid,
	input  logic mix_valid,
	input  flight_pkg::motor_level_t motor_1_level,
	input  flight_pkg::motor_level_t motor_2_level,
	input  flight_pkg::motor_level_t motor_3_level,
	input  flight_pkg::motor_level_t motor_4_level,
	input  logic motor_1_pwm,
	input  logic motor_2_pwm,
	input  logic motor_3_pwm,
	input  logic motor_4_pwm
);
	import flight_pkg::*;

	mix_single: assert property (@(posedge sys_clk) disable iff (!resetn)
		mix_valid |=> !mix_valid)  // One-cycle strobe
		else $error("mix_valid stayed high for more than one cycle");

	// Angle, two axis stages, mixer
	mix_latency: assert property (@(posedge sys_clk) disable iff (!resetn)
		imu_valid |-> ##4 mix_valid)
		else $error("mix_valid did not follow imu_valid after 4 cycles");

	mix_source: assert property (@(posedge sys_clk) disable iff (!resetn)
		mix_valid |-> $past(imu_valid, 4))  // No spurious mix strobes
		else $error("mix_valid without an imu_valid 4 cycles earlier");

	level_range: assert property (@(posedge sys_clk) disable iff (!resetn)
		(motor_1_level <= RC_MAX) && (motor_2_level <= RC_MAX) &&
		(motor_3_level <= RC_MAX) && (motor_4_level <= RC_MAX))
		else $error("A motor level exceeds full scale");

	// From the second reset cycle on, flops are known
	pwm_in_reset: assert property (@(posedge sys_clk)
		(!resetn && $past(!resetn)) |-> !(motor_1_pwm | motor_2_pwm | motor_3_pwm | motor_4_pwm))
		else $error("A motor PWM output is high during reset");

endmodule

bind flight_ctrl_top flight_ctrl_chk chk_i (.*);

// ==== verif/flight_ctrl_tb.sv ====
module flight_ctrl_tb;
	import flight_pkg::*;

	localparam int CH_THR = 0, CH_ROLL = 1, CH_PITCH = 2, CH_YAW = 3;  // rc_pwm bit order
	localparam int GAP_US = 10;                                    // Decoder publishes in the gap
	localparam int PULSE_BUDGET = 17 * (2000 + GAP_US) * US_DIV;   // 17 channel pulses at most
	localparam int TIMEOUT_CYCLES = 2 * (PULSE_BUDGET + 4 * PWM_PERIOD_US * US_DIV) + 1000;

	logic sys_clk = 1'b0;
	logic resetn;
	logic [3:0] rc_pwm;
	logic imu_valid;
	imu_val_t euler_roll, euler_pitch, gyro_roll, gyro_pitch, gyro_yaw;
	logic [3:0] motor_pwm;
	motor_level_t lvl [4];
	logic mix_valid;

	int stick_us [4];              // Last pulse width sent per channel
	int integ_m [AXIS_COUNT];      // Model integrators
	int exp_level [4];
	int lcg_state = 33892;
	int err_cnt = 0;
	int check_cnt = 0;
	int cycle_cnt = 0;

	flight_ctrl_top dut_i (
		.sys_clk, .resetn,
		.throttle_pwm(rc_pwm[CH_THR]), .roll_pwm(rc_pwm[CH_ROLL]),
		.pitch_pwm(rc_pwm[CH_PITCH]), .yaw_pwm(rc_pwm[CH_YAW]),
		.imu_valid, .euler_roll, .euler_pitch, .gyro_roll, .gyro_pitch, .gyro_yaw,
		.motor_1_pwm(motor_pwm[0]), .motor_2_pwm(motor_pwm[1]),
		.motor_3_pwm(motor_pwm[2]), .motor_4_pwm(motor_pwm[3]),
		.motor_1_level(lvl[0]), .motor_2_level(lvl[1]),
		.motor_3_level(lvl[2]), .motor_4_level(lvl[3]),
		.mix_valid);

	always #4 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("ERROR: run stopped after %0d cycles, a test is stuck", cycle_cnt);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic int lcg_next();
		lcg_state = (lcg_state * 1103515245 + 12345) & 32'h7fffffff;
		return lcg_state;
	endfunction

	function automatic int pick_in_range(int lo, int hi);
		return lo + (lcg_next() % (hi - lo + 1));
	endfunction

	function automatic int clamp_int(int v, int lo, int hi);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	task automatic tick();
		@(posedge sys_clk);
		#1;  // Drive and sample clear of the edge
	endtask

	task automatic check_value(input string test, input string what, input int exp, input int got);
		check_cnt++;
		assert (got == exp) else begin
			$display("FAILED %s: %s expected %0d, actual %0d", test, what, exp, got);
			err_cnt++;
		end
	endtask

	task automatic send_rc_pulse(input int ch, input int width_us);
		stick_us[ch] = width_us;
		rc_pwm[ch] = 1'b1;
		repeat (width_us * US_DIV) tick();
		rc_pwm[ch] = 1'b0;
		repeat (GAP_US * US_DIV) tick();
	endtask

	task automatic set_sticks(input int thr_us, input int roll_us, input int pitch_us,
		input int yaw_us);
		send_rc_pulse(CH_THR, thr_us);
		send_rc_pulse(CH_ROLL, roll_us);
		send_rc_pulse(CH_PITCH, pitch_us);
		send_rc_pulse(CH_YAW, yaw_us);
	endtask

	// Angle loop, PI loops and X-frame mix for one IMU sample
	task automatic model_step();
		int stick [4];
		int target [AXIS_COUNT];
		int gyro_v [AXIS_COUNT];
		int cmd [AXIS_COUNT];
		int err;
		for (int c = 0; c < 4; c++) stick[c] = clamp_int(stick_us[c] - PULSE_MIN_US, 0, RC_MAX);
		target[AXIS_ROLL] = (stick[CH_ROLL] - RC_CENTER - int'(euler_roll)) >>> ANGLE_SHIFT;
		target[AXIS_PITCH] = (stick[CH_PITCH] - RC_CENTER - int'(euler_pitch)) >>> ANGLE_SHIFT;
		target[AXIS_YAW] = stick[CH_YAW] - RC_CENTER;
		gyro_v[AXIS_ROLL] = int'(gyro_roll);
		gyro_v[AXIS_PITCH] = int'(gyro_pitch);
		gyro_v[AXIS_YAW] = int'(gyro_yaw);
		for (int k = 0; k < AXIS_COUNT; k++) begin
			err = target[k] - gyro_v[k];
			integ_m[k] = clamp_int(integ_m[k] + err, -INT_LIMIT, INT_LIMIT);
			cmd[k] = clamp_int((err >>> KP_SHIFT) + (integ_m[k] >>> KI_SHIFT), -CMD_LIMIT, CMD_LIMIT);
		end
		exp_level[0] = stick[CH_THR] + cmd[AXIS_PITCH] + cmd[AXIS_ROLL] - cmd[AXIS_YAW];
		exp_level[1] = stick[CH_THR] + cmd[AXIS_PITCH] - cmd[AXIS_ROLL] + cmd[AXIS_YAW];
		exp_level[2] = stick[CH_THR] - cmd[AXIS_PITCH] - cmd[AXIS_ROLL] - cmd[AXIS_YAW];
		exp_level[3] = stick[CH_THR] - cmd[AXIS_PITCH] + cmd[AXIS_ROLL] + cmd[AXIS_YAW];
		for (int m = 0; m < 4; m++) begin
			exp_level[m] = (stick[CH_THR] < ARM_THRESHOLD) ? 0 : clamp_int(exp_level[m], 0, RC_MAX);
		end
	endtask

	task automatic strobe_imu(input string test);
		int lat;
		model_step();
		imu_valid = 1'b1;
		tick();
		imu_valid = 1'b0;
		lat = 1;
		while (!mix_valid && lat < 16) begin
			tick();
			lat++;
		end
		check_cnt++;
		assert (mix_valid) else begin
			$display("ERROR %s: mix_valid never followed imu_valid", test);
			err_cnt++;
		end
		check_value(test, "mix_valid latency", 4, lat);
		for (int m = 0; m < 4; m++) begin
			check_value(test, $sformatf("motor_%0d level", m + 1), exp_level[m], lvl[m]);
		end
	endtask

	task automatic test_reset_idle();
		bit busy;
		busy = 1'b0;
		repeat (64) begin
			busy |= mix_valid | (|motor_pwm);
			tick();
		end
		check_cnt++;
		assert (!busy) else begin
			$display("ERROR reset_idle: mix_valid or a motor PWM went high with no input");
			err_cnt++;
		end
		for (int m = 0; m < 4; m++) check_value("reset_idle", "motor level", 0, lvl[m]);
	endtask

	task automatic test_disarm();
		set_sticks(1020, 1500, 1500, 1500);  // Throttle of 20 sits below the arm threshold
		strobe_imu("disarm");
		for (int m = 0; m < 4; m++) check_value("disarm", "motor level", 0, lvl[m]);
	endtask

	task automatic test_hover();
		set_sticks(1600, 1500, 1500, 1500);
		strobe_imu("hover");
		for (int m = 0; m < 4; m++) check_value("hover", "motor level", 600, lvl[m]);
	endtask

	task automatic test_rate_loop();
		euler_pitch = imu_val_t'(pick_in_range(20, 200));
		gyro_yaw = imu_val_t'(pick_in_range(-150, -20));
		set_sticks(1500, pick_in_range(1550, 1850), 1500, 1500);
		repeat (3) strobe_imu("rate_loop");  // Integrators grow each sample
	endtask

	task automatic test_pwm_frame();
		int high_cyc;
		int period_cyc;
		while (motor_pwm[0]) tick();   // Skip a frame already under way
		while (!motor_pwm[0]) tick();
		while (motor_pwm[0]) tick();
		while (!motor_pwm[0]) tick();  // Second full frame starts here
		high_cyc = 0;
		period_cyc = 0;
		while (motor_pwm[0]) begin
			high_cyc++;
			tick();
		end
		period_cyc = high_cyc;
		while (!motor_pwm[0]) begin
			period_cyc++;
			tick();
		end
		check_value("pwm_frame", "high cycles", (PULSE_MIN_US + exp_level[0]) * US_DIV, high_cyc);
		check_value("pwm_frame", "frame cycles", PWM_PERIOD_US * US_DIV, period_cyc);
	endtask

	task automatic test_saturation();
		euler_roll = -16'sd400;
		euler_pitch = 16'sd400;
		gyro_roll = -16'sd600;
		gyro_pitch = 16'sd600;
		gyro_yaw = 16'sd600;
		set_sticks(1900, 1900, 1100, 1100);  // Errors of 1000 on every axis
		repeat (4) strobe_imu("saturation");
		check_value("saturation", "motor_1 level at full", RC_MAX, lvl[0]);
		// Small opposite errors unwind the clamped integrators below the command limit
		gyro_roll = 16'sd600;
		gyro_pitch = -16'sd600;
		gyro_yaw = -16'sd600;
		send_rc_pulse(CH_THR, 1100);
		repeat (2) strobe_imu("saturation");
		check_value("saturation", "motor_2 level at zero", 0, lvl[1]);
	endtask

	initial begin
		resetn = 1'b0;
		rc_pwm = '0;
		imu_valid = 1'b0;
		euler_roll = '0;
		euler_pitch = '0;
		gyro_roll = '0;
		gyro_pitch = '0;
		gyro_yaw = '0;
		foreach (stick_us[c]) stick_us[c] = PULSE_MIN_US;  // Decoders reset to stick zero
		foreach (integ_m[k]) integ_m[k] = 0;
		foreach (exp_level[m]) exp_level[m] = 0;
		repeat (8) @(posedge sys_clk);
		#1;
		resetn = 1'b1;
		test_reset_idle();
		test_disarm();
		test_hover();
		test_rate_loop();
		test_pwm_frame();   // Measured on the moderate levels left by the rate loop
		test_saturation();
		$display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== build.f ====
common/flight_pkg.sv
verilog/us_tick.sv
receiver/rc_pulse_decoder.sv
control/angle_controller.sv
control/axis_rate_controller.sv
control/motor_mixer.sv
verilog/esc_pwm_generator.sv
verilog/flight_ctrl_top.sv
verif/flight_ctrl_chk.sv
verif/flight_ctrl_tb.sv
